// File: ix_pkg.sv
// Shared types and sizes for the integer execute stage.
// Imported by the RTL modules and by the testbench.

package ix_pkg;

    localparam int NUM_LANES = 4;
    localparam int NUM_THREADS = 4;
    localparam int SCALAR_WIDTH = 32;

    // Lane and thread values
    typedef logic [SCALAR_WIDTH-1:0] scalar_t;
    typedef scalar_t [NUM_LANES-1:0] vector_t;
    typedef logic [NUM_LANES-1:0] vector_mask_t;
    typedef logic [$clog2(NUM_THREADS)-1:0] thread_idx_t;
    typedef logic [NUM_THREADS-1:0] thread_bits_t;
    typedef scalar_t [NUM_THREADS-1:0] eret_table_t;

    // Result of a zero count, 0 to 32
    typedef logic [$clog2(SCALAR_WIDTH):0] bit_count_t;

    typedef enum logic [5:0] {
        OP_OR      = 6'h01,
        OP_AND     = 6'h03,
        OP_XOR     = 6'h05,
        OP_ADD_I   = 6'h06,
        OP_SUB_I   = 6'h07,
        OP_ASHR    = 6'h09,
        OP_SHR     = 6'h0a,
        OP_SHL     = 6'h0b,
        OP_CLZ     = 6'h0c,
        OP_CTZ     = 6'h0e,
        OP_MOVE    = 6'h0f,
        OP_CMPEQ_I = 6'h10,
        OP_CMPNE_I = 6'h11,
        OP_CMPGT_I = 6'h12,
        OP_CMPGE_I = 6'h13,
        OP_CMPLT_I = 6'h14,
        OP_CMPLE_I = 6'h15,
        OP_CMPGT_U = 6'h16,
        OP_CMPGE_U = 6'h17,
        OP_CMPLT_U = 6'h18,
        OP_CMPLE_U = 6'h19,
        OP_SEXT8   = 6'h1d,
        OP_SEXT16  = 6'h1e
    } alu_op_t;

    typedef enum logic [2:0] {
        BRANCH_ZERO          = 3'd0,
        BRANCH_NOT_ZERO      = 3'd1,
        BRANCH_ALWAYS        = 3'd2,
        BRANCH_CALL_OFFSET   = 3'd3,
        BRANCH_CALL_REGISTER = 3'd4,
        BRANCH_REGISTER      = 3'd5,
        BRANCH_ERET          = 3'd6
    } branch_type_t;

    typedef enum logic [1:0] {
        PIPE_MEM         = 2'd0,
        PIPE_INT_ARITH   = 2'd1,
        PIPE_FLOAT_ARITH = 2'd2
    } pipe_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        pipe_sel_t pipeline_sel;
        logic branch;
        branch_type_t branch_type;
        scalar_t pc;
        scalar_t immediate_value;
    } decoded_inst_t;

    typedef struct packed {
        logic valid;
        logic taken;
        logic conditional;
        logic fault;
        scalar_t target;
    } branch_decision_t;

    typedef struct packed {
        logic uncond_branch;
        logic cond_taken;
        logic cond_not_taken;
    } perf_events_t;

    typedef struct packed {
        logic en;
        scalar_t pc;
    } rollback_t;

endpackage

// File: int_lane_alu.sv
// Single-lane integer ALU, purely combinational.
// One copy per vector lane, the operation is shared by all lanes.
`timescale 1ns/1ps

module int_lane_alu (
    input ix_pkg::alu_op_t alu_op,
    input ix_pkg::scalar_t operand1,
    input ix_pkg::scalar_t operand2,
    output ix_pkg::scalar_t result
);
    import ix_pkg::*;

    scalar_t difference;
    logic borrow;
    logic zero;
    logic negative;
    logic overflow;
    logic signed_gtr;
    bit_count_t lz;
    bit_count_t tz;
    scalar_t shr_result;
    scalar_t ashr_result;
    scalar_t shl_result;

    // Extra top bit catches the unsigned borrow
    assign {borrow, difference} = {1'b0, operand1} - {1'b0, operand2};
    assign zero = difference == '0;
    assign negative = difference[SCALAR_WIDTH-1];

    // Signed overflow when the operand signs differ and the result
    // sign follows operand2
    assign overflow = operand2[SCALAR_WIDTH-1] == negative
        && operand1[SCALAR_WIDTH-1] != operand2[SCALAR_WIDTH-1];
    assign signed_gtr = overflow == negative;

    assign shr_result = operand1 >> operand2[4:0];
    assign ashr_result = scalar_t'($signed(operand1) >>> operand2[4:0]);
    assign shl_result = operand1 << operand2[4:0];

    // Leading zeros, the highest set bit wins
    always_comb
    begin
        lz = bit_count_t'(SCALAR_WIDTH);
        for (int i = 0; i < SCALAR_WIDTH; i++)
        begin
            if (operand2[i])
                lz = bit_count_t'(SCALAR_WIDTH - 1 - i);
        end
    end

    // Trailing zeros, the lowest set bit wins
    always_comb
    begin
        tz = bit_count_t'(SCALAR_WIDTH);
        for (int i = SCALAR_WIDTH - 1; i >= 0; i--)
        begin
            if (operand2[i])
                tz = bit_count_t'(i);
        end
    end

    always_comb
    begin
        case (alu_op)
            OP_SHR:
                result = shr_result;
            OP_ASHR:
                result = ashr_result;
            OP_SHL:
                result = shl_result;
            OP_MOVE:
                result = operand2;
            OP_OR:
                result = operand1 | operand2;
            OP_AND:
                result = operand1 & operand2;
            OP_XOR:
                result = operand1 ^ operand2;
            OP_ADD_I:
                result = operand1 + operand2;
            OP_SUB_I:
                result = difference;

            // Compares return 0 or 1
            OP_CMPEQ_I:
                result = scalar_t'(zero);
            OP_CMPNE_I:
                result = scalar_t'(!zero);
            OP_CMPGT_I:
                result = scalar_t'(signed_gtr && !zero);
            OP_CMPGE_I:
                result = scalar_t'(signed_gtr || zero);
            OP_CMPLT_I:
                result = scalar_t'(!signed_gtr && !zero);
            OP_CMPLE_I:
                result = scalar_t'(!signed_gtr || zero);
            OP_CMPGT_U:
                result = scalar_t'(!borrow && !zero);
            OP_CMPGE_U:
                result = scalar_t'(!borrow || zero);
            OP_CMPLT_U:
                result = scalar_t'(borrow && !zero);
            OP_CMPLE_U:
                result = scalar_t'(borrow || zero);

            OP_CLZ:
                result = scalar_t'(lz);
            OP_CTZ:
                result = scalar_t'(tz);
            OP_SEXT8:
                result = {{24{operand2[7]}}, operand2[7:0]};
            OP_SEXT16:
                result = {{16{operand2[15]}}, operand2[15:0]};
            default:
                result = '0;
        endcase
    end

    // Known inputs must always give a known lane value
    always_comb
    begin
        if (!$isunknown({alu_op, operand1, operand2}))
        begin
            assert final (!$isunknown(result))
            else $error("lane ALU produced unknown result for op %0h", alu_op);
        end
    end

endmodule

// File: branch_resolve.sv
// Qualifies the instruction for this pipeline and resolves its branch.
// Lane 0 supplies the condition and the register target.
`timescale 1ns/1ps

module branch_resolve (
    input logic instruction_valid,
    input ix_pkg::decoded_inst_t instruction,
    input ix_pkg::thread_idx_t thread_idx,
    input logic rollback_en,
    input ix_pkg::thread_idx_t rollback_thread_idx,
    input ix_pkg::scalar_t lane0_operand1,
    input ix_pkg::eret_table_t eret_address,
    input ix_pkg::thread_bits_t supervisor_en,
    output ix_pkg::branch_decision_t decision
);
    import ix_pkg::*;

    logic squashed;
    logic valid;
    logic eret;
    logic fault;
    logic taken;
    logic conditional;
    scalar_t target;

    // Writeback is rolling back this thread, drop the instruction
    assign squashed = rollback_en && rollback_thread_idx == thread_idx;
    assign valid = instruction_valid && !squashed
        && instruction.pipeline_sel == PIPE_INT_ARITH;

    // eret is privileged
    assign eret = valid && instruction.branch && instruction.branch_type == BRANCH_ERET;
    assign fault = eret && !supervisor_en[thread_idx];

    always_comb
    begin
        taken = 1'b0;
        conditional = 1'b0;
        if (valid && instruction.branch && !fault)
        begin
            case (instruction.branch_type)
                BRANCH_ZERO:
                begin
                    taken = !lane0_operand1[0];
                    conditional = 1'b1;
                end
                BRANCH_NOT_ZERO:
                begin
                    taken = lane0_operand1[0];
                    conditional = 1'b1;
                end
                BRANCH_ALWAYS, BRANCH_CALL_OFFSET, BRANCH_CALL_REGISTER,
                BRANCH_REGISTER, BRANCH_ERET:
                    taken = 1'b1;
                default:
                    taken = 1'b0;
            endcase
        end
    end

    // Target is computed regardless of taken
    always_comb
    begin
        case (instruction.branch_type)
            BRANCH_CALL_REGISTER, BRANCH_REGISTER:
                target = lane0_operand1;
            BRANCH_ERET:
                target = eret_address[thread_idx];
            default:
                target = instruction.pc + instruction.immediate_value;
        endcase
    end

    always_comb
    begin
        decision.valid = valid;
        decision.taken = taken;
        decision.conditional = conditional;
        decision.fault = fault;
        decision.target = target;
        assert final (!(decision.fault && decision.taken))
        else $error("privileged fault with branch taken");
    end

endmodule

// File: ix_result_reg.sv
// Output register of the execute stage, one cycle of latency.
// Control outputs and performance pulses are cleared by reset.
`timescale 1ns/1ps

module ix_result_reg (
    input logic clk,
    input logic reset,
    input ix_pkg::branch_decision_t decision,
    input ix_pkg::vector_t lane_results,
    input ix_pkg::decoded_inst_t instruction,
    input ix_pkg::vector_mask_t mask_value,
    input ix_pkg::thread_idx_t thread_idx,
    output logic ix_instruction_valid,
    output ix_pkg::decoded_inst_t ix_instruction,
    output ix_pkg::vector_t ix_result,
    output ix_pkg::vector_mask_t ix_mask_value,
    output ix_pkg::thread_idx_t ix_thread_idx,
    output ix_pkg::rollback_t ix_rollback,
    output logic ix_privileged_op_fault,
    output ix_pkg::perf_events_t ix_perf
);
    import ix_pkg::*;

    logic rollback_en;
    scalar_t rollback_pc;

    // Payload
    always_ff @(posedge clk)
    begin
        ix_instruction <= instruction;
        ix_result <= lane_results;
        ix_mask_value <= mask_value;
        ix_thread_idx <= thread_idx;
        rollback_pc <= decision.target;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ix_instruction_valid <= 1'b0;
            rollback_en <= 1'b0;
            ix_privileged_op_fault <= 1'b0;
            ix_perf <= '0;
        end
        else
        begin
            ix_instruction_valid <= decision.valid;
            rollback_en <= decision.valid && decision.taken;

            // Fault holds until the next valid instruction
            if (decision.valid)
                ix_privileged_op_fault <= decision.fault;

            // taken and conditional are already qualified by valid
            ix_perf.uncond_branch <= !decision.conditional && decision.taken;
            ix_perf.cond_taken <= decision.conditional && decision.taken;
            ix_perf.cond_not_taken <= decision.conditional && !decision.taken;
        end
    end

    assign ix_rollback.en = rollback_en;
    assign ix_rollback.pc = rollback_pc;

    // A rollback is only ever requested by an instruction that executed
    assert property (@(posedge clk) disable iff (reset)
        ix_rollback.en |-> ix_instruction_valid)
    else $error("rollback without a valid instruction");

endmodule

// File: int_execute_stage.sv
// Integer execute stage, top level.
// Four lane ALUs and lane 0 branch resolution feed one register stage.
`timescale 1ns/1ps

module int_execute_stage (
    input logic clk,
    input logic reset,

    // Operand fetch
    input logic of_instruction_valid,
    input ix_pkg::decoded_inst_t of_instruction,
    input ix_pkg::vector_t of_operand1,
    input ix_pkg::vector_t of_operand2,
    input ix_pkg::vector_mask_t of_mask_value,
    input ix_pkg::thread_idx_t of_thread_idx,

    // Writeback
    input logic wb_rollback_en,
    input ix_pkg::thread_idx_t wb_rollback_thread_idx,

    // Control registers
    input ix_pkg::eret_table_t cr_eret_address,
    input ix_pkg::thread_bits_t cr_supervisor_en,

    // To writeback and performance counters
    output logic ix_instruction_valid,
    output ix_pkg::decoded_inst_t ix_instruction,
    output ix_pkg::vector_t ix_result,
    output ix_pkg::vector_mask_t ix_mask_value,
    output ix_pkg::thread_idx_t ix_thread_idx,
    output ix_pkg::rollback_t ix_rollback,
    output logic ix_privileged_op_fault,
    output ix_pkg::perf_events_t ix_perf
);
    import ix_pkg::*;

    vector_t lane_results;
    branch_decision_t decision;

    genvar lane;
    generate
        for (lane = 0; lane < NUM_LANES; lane++)
        begin : lane_alu_gen
            int_lane_alu u_int_lane_alu (
                .alu_op(of_instruction.alu_op),
                .operand1(of_operand1[lane]),
                .operand2(of_operand2[lane]),
                .result(lane_results[lane])
            );
        end
    endgenerate

    branch_resolve u_branch_resolve (
        .instruction_valid(of_instruction_valid),
        .instruction(of_instruction),
        .thread_idx(of_thread_idx),
        .rollback_en(wb_rollback_en),
        .rollback_thread_idx(wb_rollback_thread_idx),
        .lane0_operand1(of_operand1[0]),
        .eret_address(cr_eret_address),
        .supervisor_en(cr_supervisor_en),
        .decision(decision)
    );

    ix_result_reg u_ix_result_reg (
        .clk(clk),
        .reset(reset),
        .decision(decision),
        .lane_results(lane_results),
        .instruction(of_instruction),
        .mask_value(of_mask_value),
        .thread_idx(of_thread_idx),
        .ix_instruction_valid(ix_instruction_valid),
        .ix_instruction(ix_instruction),
        .ix_result(ix_result),
        .ix_mask_value(ix_mask_value),
        .ix_thread_idx(ix_thread_idx),
        .ix_rollback(ix_rollback),
        .ix_privileged_op_fault(ix_privileged_op_fault),
        .ix_perf(ix_perf)
    );

endmodule

// File: tb_checks.svh
// Reference model of the lane ALU and branch rules, with typed compare tasks.
// Included inside the testbench module after the package import.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic scalar_t model_alu(alu_op_t op, scalar_t a, scalar_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    scalar_t v;
    int count;
    sa = a;
    sb = b;
    v = b;
    count = 0;
    case (op)
        OP_OR: return a | b;
        OP_AND: return a & b;
        OP_XOR: return a ^ b;
        OP_ADD_I: return a + b;
        OP_SUB_I: return a - b;
        OP_ASHR: return scalar_t'(sa >>> b[4:0]);
        OP_SHR: return a >> b[4:0];
        OP_SHL: return a << b[4:0];
        OP_MOVE: return b;
        OP_CMPEQ_I: return scalar_t'(a == b);
        OP_CMPNE_I: return scalar_t'(a != b);
        OP_CMPGT_I: return scalar_t'(sa > sb);
        OP_CMPGE_I: return scalar_t'(sa >= sb);
        OP_CMPLT_I: return scalar_t'(sa < sb);
        OP_CMPLE_I: return scalar_t'(sa <= sb);
        OP_CMPGT_U: return scalar_t'(a > b);
        OP_CMPGE_U: return scalar_t'(a >= b);
        OP_CMPLT_U: return scalar_t'(a < b);
        OP_CMPLE_U: return scalar_t'(a <= b);
        OP_SEXT8: return scalar_t'($signed(b[7:0]));
        OP_SEXT16: return scalar_t'($signed(b[15:0]));
        OP_CLZ:
        begin
            // Shift the top bit out until a one shows up
            while (count < 32 && !v[31])
            begin
                v = v << 1;
                count++;
            end
            return scalar_t'(count);
        end
        OP_CTZ:
        begin
            while (count < 32 && !v[0])
            begin
                v = v >> 1;
                count++;
            end
            return scalar_t'(count);
        end
        default: return '0;
    endcase
endfunction

function automatic logic is_conditional(branch_type_t kind);
    return kind == BRANCH_ZERO || kind == BRANCH_NOT_ZERO;
endfunction

function automatic logic model_taken(branch_type_t kind, logic bit0, logic supervisor);
    case (kind)
        BRANCH_ZERO: return !bit0;
        BRANCH_NOT_ZERO: return bit0;
        BRANCH_ERET: return supervisor;
        default: return 1'b1;
    endcase
endfunction

function automatic scalar_t model_target(branch_type_t kind, scalar_t pc, scalar_t imm,
                                         scalar_t reg_value, scalar_t eret_value);
    case (kind)
        BRANCH_CALL_REGISTER, BRANCH_REGISTER: return reg_value;
        BRANCH_ERET: return eret_value;
        default: return pc + imm;
    endcase
endfunction

function automatic perf_events_t model_perf(branch_type_t kind, logic taken);
    perf_events_t perf;
    perf = '0;
    if (is_conditional(kind))
    begin
        perf.cond_taken = taken;
        perf.cond_not_taken = !taken;
    end
    else
        perf.uncond_branch = taken;
    return perf;
endfunction

task automatic compare_vector(string name, vector_t got, vector_t expected);
    if (got !== expected)
    begin
        $display("ERR %s got %h expected %h", name, got, expected);
        fail_run();
    end
endtask

task automatic compare_scalar(string name, scalar_t got, scalar_t expected);
    if (got !== expected)
    begin
        $display("ERR %s got %h expected %h", name, got, expected);
        fail_run();
    end
endtask

task automatic compare_bit(string name, logic got, logic expected);
    if (got !== expected)
    begin
        $display("ERR %s got %h expected %h", name, got, expected);
        fail_run();
    end
endtask

task automatic compare_perf(string name, perf_events_t got, perf_events_t expected);
    if (got !== expected)
    begin
        $display("ERR %s got %h expected %h", name, got, expected);
        fail_run();
    end
endtask

task automatic compare_mask(string name, vector_mask_t got, vector_mask_t expected);
    if (got !== expected)
    begin
        $display("ERR %s got %h expected %h", name, got, expected);
        fail_run();
    end
endtask

task automatic compare_thread(string name, thread_idx_t got, thread_idx_t expected);
    if (got !== expected)
    begin
        $display("ERR %s got %h expected %h", name, got, expected);
        fail_run();
    end
endtask

task automatic compare_inst(string name, decoded_inst_t got, decoded_inst_t expected);
    if (got !== expected)
    begin
        $display("ERR %s got %h expected %h", name, got, expected);
        fail_run();
    end
endtask

`endif

// File: tb_int_execute_stage.sv
// Directed testbench for the integer execute stage.
// Each test task drives the DUT and checks it against the model in tb_checks.svh.
`timescale 1ns/1ps

module tb_int_execute_stage;
    import ix_pkg::*;

    localparam int CLK_HALF = 5;
    localparam int CLK_PERIOD = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int TIMEOUT_NS = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;
    localparam int VECTORS_PER_OP = 8;

    logic clk = 1'b0;
    logic reset;
    logic of_instruction_valid;
    decoded_inst_t of_instruction;
    vector_t of_operand1;
    vector_t of_operand2;
    vector_mask_t of_mask_value;
    thread_idx_t of_thread_idx;
    logic wb_rollback_en;
    thread_idx_t wb_rollback_thread_idx;
    eret_table_t cr_eret_address;
    thread_bits_t cr_supervisor_en;
    logic ix_instruction_valid;
    decoded_inst_t ix_instruction;
    vector_t ix_result;
    vector_mask_t ix_mask_value;
    thread_idx_t ix_thread_idx;
    rollback_t ix_rollback;
    logic ix_privileged_op_fault;
    perf_events_t ix_perf;

    int_execute_stage u_int_execute_stage (
        .clk(clk),
        .reset(reset),
        .of_instruction_valid(of_instruction_valid),
        .of_instruction(of_instruction),
        .of_operand1(of_operand1),
        .of_operand2(of_operand2),
        .of_mask_value(of_mask_value),
        .of_thread_idx(of_thread_idx),
        .wb_rollback_en(wb_rollback_en),
        .wb_rollback_thread_idx(wb_rollback_thread_idx),
        .cr_eret_address(cr_eret_address),
        .cr_supervisor_en(cr_supervisor_en),
        .ix_instruction_valid(ix_instruction_valid),
        .ix_instruction(ix_instruction),
        .ix_result(ix_result),
        .ix_mask_value(ix_mask_value),
        .ix_thread_idx(ix_thread_idx),
        .ix_rollback(ix_rollback),
        .ix_privileged_op_fault(ix_privileged_op_fault),
        .ix_perf(ix_perf)
    );

    always #CLK_HALF clk = ~clk;

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_checks.svh"

    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
        fail_run();
    end

    // Ends 1 ns after the rising edge, where inputs change and outputs are stable
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic decoded_inst_t make_inst(alu_op_t op, pipe_sel_t pipe, logic branch,
                                                branch_type_t kind, scalar_t pc, scalar_t imm);
        decoded_inst_t inst;
        inst.alu_op = op;
        inst.pipeline_sel = pipe;
        inst.branch = branch;
        inst.branch_type = kind;
        inst.pc = pc;
        inst.immediate_value = imm;
        return inst;
    endfunction

    // Kind 0 random, 1 edge value, 2 one-hot
    function automatic scalar_t pick_operand(int kind);
        if (kind == 1)
        begin
            case ($urandom % 4)
                0: return 32'h0;
                1: return 32'hffff_ffff;
                2: return 32'h80;
                default: return 32'h8000;
            endcase
        end
        else if (kind == 2)
            return scalar_t'(1) << ($urandom % 32);
        return $urandom;
    endfunction

    task automatic drive_inst(logic valid, decoded_inst_t inst, vector_t a, vector_t b,
                              vector_mask_t mask, thread_idx_t thread);
        of_instruction_valid = valid;
        of_instruction = inst;
        of_operand1 = a;
        of_operand2 = b;
        of_mask_value = mask;
        of_thread_idx = thread;
    endtask

    task automatic idle();
        of_instruction_valid = 1'b0;
        next_cycle();
    endtask

    task automatic check_controls_clear(string when);
        compare_bit({"ix_instruction_valid ", when}, ix_instruction_valid, 1'b0);
        compare_bit({"ix_rollback.en ", when}, ix_rollback.en, 1'b0);
        compare_bit({"ix_privileged_op_fault ", when}, ix_privileged_op_fault, 1'b0);
        compare_perf({"ix_perf ", when}, ix_perf, '0);
    endtask

    task automatic reset_state();
        repeat (RESET_CYCLES / 2) @(posedge clk);
        #1;
        check_controls_clear("during reset");
        repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();
        check_controls_clear("after reset");
    endtask

    task automatic alu_ops();
        alu_op_t op_list [0:22];
        vector_t a;
        vector_t b;
        vector_t expected;
        vector_mask_t mask;
        thread_idx_t thread;
        decoded_inst_t inst;
        op_list = '{OP_OR, OP_AND, OP_XOR, OP_ADD_I, OP_SUB_I, OP_ASHR, OP_SHR, OP_SHL,
                    OP_CLZ, OP_CTZ, OP_MOVE, OP_CMPEQ_I, OP_CMPNE_I, OP_CMPGT_I,
                    OP_CMPGE_I, OP_CMPLT_I, OP_CMPLE_I, OP_CMPGT_U, OP_CMPGE_U,
                    OP_CMPLT_U, OP_CMPLE_U, OP_SEXT8, OP_SEXT16};
        for (int i = 0; i < 23; i++)
        begin
            for (int v = 0; v < VECTORS_PER_OP; v++)
            begin
                for (int lane = 0; lane < NUM_LANES; lane++)
                begin
                    a[lane] = pick_operand(v % 3);
                    b[lane] = pick_operand((v / 3) % 3);
                end
                // Equal operands for the compare corner
                if (v == VECTORS_PER_OP - 1)
                    b = a;
                mask = vector_mask_t'($urandom);
                thread = thread_idx_t'($urandom);
                inst = make_inst(op_list[i], PIPE_INT_ARITH, 1'b0, BRANCH_ZERO, '0, '0);
                drive_inst(1'b1, inst, a, b, mask, thread);
                for (int lane = 0; lane < NUM_LANES; lane++)
                    expected[lane] = model_alu(op_list[i], a[lane], b[lane]);
                next_cycle();
                compare_vector({"ix_result op ", op_list[i].name()}, ix_result, expected);
                compare_bit("ix_instruction_valid", ix_instruction_valid, 1'b1);
                compare_bit("ix_rollback.en", ix_rollback.en, 1'b0);
                compare_mask("ix_mask_value", ix_mask_value, mask);
                compare_thread("ix_thread_idx", ix_thread_idx, thread);
                compare_inst("ix_instruction", ix_instruction, inst);
            end
        end
        idle();
    endtask

    task automatic branches();
        branch_type_t kinds [0:6];
        vector_t a;
        scalar_t pc;
        scalar_t imm;
        thread_idx_t thread;
        logic bit0;
        logic taken;
        scalar_t target;
        decoded_inst_t inst;
        kinds = '{BRANCH_ZERO, BRANCH_NOT_ZERO, BRANCH_ALWAYS, BRANCH_CALL_OFFSET,
                  BRANCH_CALL_REGISTER, BRANCH_REGISTER, BRANCH_ERET};
        cr_supervisor_en = '1;
        for (int k = 0; k < 7; k++)
        begin
            for (int c = 1; c >= 0; c--)
            begin
                bit0 = (c == 1);
                for (int t = 0; t < NUM_THREADS; t++)
                    cr_eret_address[t] = $urandom;
                for (int lane = 0; lane < NUM_LANES; lane++)
                    a[lane] = $urandom;
                a[0][0] = bit0;
                pc = $urandom;
                imm = $urandom;
                thread = thread_idx_t'($urandom);
                taken = model_taken(kinds[k], bit0, 1'b1);
                target = model_target(kinds[k], pc, imm, a[0], cr_eret_address[thread]);
                inst = make_inst(OP_MOVE, PIPE_INT_ARITH, 1'b1, kinds[k], pc, imm);
                drive_inst(1'b1, inst, a, a, '1, thread);
                next_cycle();
                compare_bit("ix_instruction_valid", ix_instruction_valid, 1'b1);
                compare_inst({"ix_instruction ", kinds[k].name()}, ix_instruction, inst);
                compare_bit({"ix_rollback.en ", kinds[k].name()}, ix_rollback.en, taken);
                compare_scalar({"ix_rollback.pc ", kinds[k].name()}, ix_rollback.pc, target);
                compare_bit("ix_privileged_op_fault", ix_privileged_op_fault, 1'b0);
                compare_perf({"ix_perf ", kinds[k].name()}, ix_perf,
                             model_perf(kinds[k], taken));
                // Pulse must drop after one cycle
                idle();
                compare_perf("ix_perf after pulse", ix_perf, '0);
            end
        end
    endtask

    task automatic eret_privilege();
        vector_t a;
        thread_idx_t thread;
        logic taken;
        for (int t = 0; t < NUM_THREADS; t++)
        begin
            thread = thread_idx_t'(t);
            for (int s = 1; s >= 0; s--)
            begin
                for (int i = 0; i < NUM_THREADS; i++)
                    cr_eret_address[i] = $urandom;
                for (int lane = 0; lane < NUM_LANES; lane++)
                    a[lane] = $urandom;
                if (s == 1)
                    cr_supervisor_en = thread_bits_t'(1) << t;
                else
                    cr_supervisor_en = ~(thread_bits_t'(1) << t);
                taken = model_taken(BRANCH_ERET, a[0][0], s == 1);
                drive_inst(1'b1, make_inst(OP_MOVE, PIPE_INT_ARITH, 1'b1, BRANCH_ERET,
                           $urandom, $urandom), a, a, '1, thread);
                next_cycle();
                compare_bit("ix_instruction_valid", ix_instruction_valid, 1'b1);
                compare_bit("ix_rollback.en eret", ix_rollback.en, taken);
                if (taken)
                    compare_scalar("ix_rollback.pc eret", ix_rollback.pc,
                                   cr_eret_address[thread]);
                compare_bit("ix_privileged_op_fault", ix_privileged_op_fault, s == 0);
                compare_perf("ix_perf eret", ix_perf, model_perf(BRANCH_ERET, taken));
            end
        end
        idle();
    endtask

    // Thread 2 issues an unconditional branch on the given pipeline
    task automatic squash_case(string label, pipe_sel_t pipe, logic wb_en,
                               thread_idx_t wb_thread, logic exp_valid);
        wb_rollback_en = wb_en;
        wb_rollback_thread_idx = wb_thread;
        drive_inst(1'b1, make_inst(OP_ADD_I, pipe, 1'b1, BRANCH_ALWAYS, $urandom, $urandom),
                   '0, '0, '1, thread_idx_t'(2));
        next_cycle();
        compare_bit({"ix_instruction_valid ", label}, ix_instruction_valid, exp_valid);
        compare_bit({"ix_rollback.en ", label}, ix_rollback.en, exp_valid);
        compare_perf({"ix_perf ", label}, ix_perf, model_perf(BRANCH_ALWAYS, exp_valid));
    endtask

    task automatic squash_and_pipe();
        squash_case("same thread rollback", PIPE_INT_ARITH, 1'b1, thread_idx_t'(2), 1'b0);
        squash_case("other thread rollback", PIPE_INT_ARITH, 1'b1, thread_idx_t'(1), 1'b1);
        squash_case("memory pipe", PIPE_MEM, 1'b0, thread_idx_t'(2), 1'b0);
        squash_case("float pipe", PIPE_FLOAT_ARITH, 1'b0, thread_idx_t'(2), 1'b0);
        wb_rollback_en = 1'b0;
        idle();
    endtask

    initial
    begin
        void'($urandom(32'h9fe6));
        reset = 1'b1;
        of_instruction_valid = 1'b0;
        of_instruction = make_inst(OP_MOVE, PIPE_INT_ARITH, 1'b0, BRANCH_ZERO, '0, '0);
        of_operand1 = '0;
        of_operand2 = '0;
        of_mask_value = '0;
        of_thread_idx = '0;
        wb_rollback_en = 1'b0;
        wb_rollback_thread_idx = '0;
        cr_eret_address = '0;
        cr_supervisor_en = '0;
        reset_state();
        alu_ops();
        branches();
        eret_privilege();
        squash_and_pipe();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
ix_pkg.sv
int_lane_alu.sv
branch_resolve.sv
ix_result_reg.sv
int_execute_stage.sv
tb_int_execute_stage.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_int_execute_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_int_execute_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
